//--- all.f
hw/sd_pkg.sv
hw/sd_spi_clock.sv
hw/sd_cmd_sender.sv
hw/sd_resp_receiver.sv
hw/sd_controller.sv
hw/sd_reader_top.sv
testbench/sd_card_model.sv
testbench/sd_reader_props.sv
testbench/sd_reader_tb.sv

//--- testbench/sd_reader_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sd_reader_tb;

  localparam logic [31:0] ADDR_LIMIT = 32'h0001_0000;
  localparam int NUM_ROWS    = 6;
  localparam int SLOW_BIT_NS = 2 * sd_pkg::SLOW_HALF * 10;
  localparam int FAST_BIT_NS = 2 * sd_pkg::FAST_HALF * 10;
  // Power-up clocks plus eight init exchanges of about 80 bits each
  localparam longint INIT_NS  = (sd_pkg::POWER_UP_CLOCKS + 8 * 80) * SLOW_BIT_NS;
  // Frame and reply gaps, then token, block and CRC
  localparam longint BLOCK_NS = (80 + (sd_pkg::BLOCK_BYTES + 4) * 8) * FAST_BIT_NS;
  localparam longint LIMIT_NS = 2 * (INIT_NS + NUM_ROWS * BLOCK_NS) + 10000;
  localparam int INIT_CYCLES  = int'(INIT_NS / 10) * 2;
  localparam int ACK_CYCLES   = int'(BLOCK_NS / 10) * 2;

  typedef struct packed {
    logic [31:0] addr;
    logic        want_error;
  } row_t;

  logic        clock;
  logic        reset;
  logic        rd_req;
  logic [31:0] rd_addr;
  logic        rd_ack;
  logic        rd_error;
  logic        init_done;
  logic [7:0]  data_byte;
  logic        data_strobe;
  logic        miso;
  logic        cs;
  logic        sck;
  logic        mosi;
  logic        card_fault;
  int          cmd0_seen;
  int          cmd8_seen;
  int          acmd41_seen;
  int          cmd17_seen;

  row_t        rows [NUM_ROWS];
  int          failures;
  int          strobe_count;  // Strobes seen in the current read
  logic [31:0] cur_addr;

  sd_reader_top DUT (
    .clock       (clock),
    .reset       (reset),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_ack      (rd_ack),
    .rd_error    (rd_error),
    .init_done   (init_done),
    .data_byte   (data_byte),
    .data_strobe (data_strobe),
    .miso        (miso),
    .cs          (cs),
    .sck         (sck),
    .mosi        (mosi)
  );

  sd_card_model #(.ADDR_LIMIT(ADDR_LIMIT)) u_card (
    .sck         (sck),
    .cs          (cs),
    .mosi        (mosi),
    .miso        (miso),
    .fault       (card_fault),
    .cmd0_seen   (cmd0_seen),
    .cmd8_seen   (cmd8_seen),
    .acmd41_seen (acmd41_seen),
    .cmd17_seen  (cmd17_seen)
  );

  bind sd_reader_top sd_reader_props u_props (
    .clock       (clock),
    .reset       (reset),
    .rd_req      (rd_req),
    .rd_ack      (rd_ack),
    .data_strobe (data_strobe),
    .cs          (cs),
    .state       (u_ctrl.state)
  );

  // Block contents as the card produces them
  function automatic logic [7:0] expected_byte(input logic [31:0] addr, input int idx);
    return (addr[7:0] + 8'(idx)) ^ 8'h5A;
  endfunction

  task automatic fail_run(input string why);
    failures++;
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic fill_rows();
    rows[0] = '{addr: 32'h0000_0000, want_error: 1'b0};
    rows[1] = '{addr: 32'h0000_12F3, want_error: 1'b0};  // Low byte wraps inside the block
    rows[2] = '{addr: ADDR_LIMIT, want_error: 1'b1};
    rows[3] = '{addr: $urandom % ADDR_LIMIT, want_error: 1'b0};
    rows[4] = '{addr: 32'hFFFF_FE00, want_error: 1'b1};
    rows[5] = '{addr: $urandom % ADDR_LIMIT, want_error: 1'b0};
  endtask

  task automatic wait_init();
    int cycles;
    cycles = 0;
    while (!init_done) begin
      @(negedge clock);
      cycles++;
      assert (cycles < INIT_CYCLES) else fail_run("init_done never rose after reset");
    end
    assert (cmd0_seen == 1 && cmd8_seen == 1 && acmd41_seen == 3 && cmd17_seen == 0)
      else fail_run($sformatf("Error at %0t: init saw CMD0 x%0d, CMD8 x%0d, ACMD41 x%0d",
                              $time, cmd0_seen, cmd8_seen, acmd41_seen));
  endtask

  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    while (rd_ack !== level) begin
      @(negedge clock);
      cycles++;
      assert (cycles < ACK_CYCLES)
        else fail_run($sformatf("rd_ack did not go to %0b in time", level));
    end
  endtask

  task automatic run_row(input row_t row);
    int hold;
    int want_count;
    want_count = row.want_error ? 0 : sd_pkg::BLOCK_BYTES;
    @(posedge clock);
    #1;
    assert (!rd_ack)
      else fail_run($sformatf("Error at %0t: rd_ack still high before a new request",
                              $time));
    cur_addr     = row.addr;
    strobe_count = 0;
    rd_addr      = row.addr;
    rd_req       = 1'b1;
    wait_ack(1'b1);
    assert (strobe_count == want_count)
      else fail_run($sformatf("Error at %0t: %0d strobes for address 0x%h, expected %0d",
                              $time, strobe_count, row.addr, want_count));
    assert (rd_error == row.want_error)
      else fail_run($sformatf("Error at %0t: rd_error %0b for address 0x%h, expected %0b",
                              $time, rd_error, row.addr, row.want_error));
    hold = $urandom % 4 + 2;
    repeat (hold) begin  // Ack must wait for the request to drop
      @(negedge clock);
      assert (rd_ack) else fail_run($sformatf("Error at %0t: rd_ack fell with rd_req high",
                                              $time));
    end
    @(posedge clock);
    #1;
    rd_req = 1'b0;
    wait_ack(1'b0);
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    #(LIMIT_NS);
    fail_run("Timeout: the run did not finish within the time limit");
  end

  // Stream and pin checks away from the driving edge
  always @(negedge clock) begin
    if (!reset) begin
      assert (!card_fault) else fail_run("The card model reported a protocol fault");
      if (init_done && (rd_ack || !rd_req)) begin
        assert (cs) else fail_run($sformatf("Error at %0t: cs low while the reader is idle",
                                            $time));
      end
      if (data_strobe) begin
        assert (!rd_ack) else fail_run($sformatf("Error at %0t: data_strobe after rd_ack",
                                                 $time));
        assert (data_byte == expected_byte(cur_addr, strobe_count))
          else fail_run($sformatf("Error at %0t: byte %0d of 0x%h is 0x%h, expected 0x%h",
                                  $time, strobe_count, cur_addr, data_byte,
                                  expected_byte(cur_addr, strobe_count)));
        strobe_count++;
      end
    end
  end

  initial begin
    void'($urandom(8620));
    failures     = 0;
    strobe_count = 0;
    cur_addr     = 32'd0;
    reset        = 1'b1;
    rd_req       = 1'b0;
    rd_addr      = 32'd0;
    fill_rows();
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    wait_init();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    assert (cmd17_seen == NUM_ROWS)
      else fail_run($sformatf("Error at %0t: card saw %0d reads, expected %0d",
                              $time, cmd17_seen, NUM_ROWS));
    if (failures == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      fail_run("Checks failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- testbench/sd_reader_props.sv
`timescale 1ns/10ps
`default_nettype none

module sd_reader_props (
  input logic                clock,
  input logic                reset,
  input logic                rd_req,
  input logic                rd_ack,
  input logic                data_strobe,
  input logic                cs,
  input sd_pkg::ctrl_state_t state
);

  ack_needs_req: assert property (@(posedge clock) disable iff (reset)
    $rose(rd_ack) |-> rd_req)
    else $error("rd_ack rose without rd_req");

  // Stream is over once the read is acknowledged
  no_strobe_in_ack: assert property (@(posedge clock) disable iff (reset)
    rd_ack |-> !data_strobe)
    else $error("data_strobe while rd_ack is high");

  cs_high_in_ack: assert property (@(posedge clock) disable iff (reset)
    rd_ack |-> cs)
    else $error("cs low while rd_ack is high");

  // Card deselected between reads
  cs_high_in_idle: assert property (@(posedge clock) disable iff (reset)
    (state == sd_pkg::ST_IDLE) |-> cs)
    else $error("cs low in ST_IDLE");

endmodule

`default_nettype wire

//--- testbench/sd_card_model.sv
`timescale 1ns/10ps
`default_nettype none

module sd_card_model #(
  parameter logic [31:0] ADDR_LIMIT = 32'h0001_0000  // First block address the card refuses
) (
  input  logic sck,
  input  logic cs,
  input  logic mosi,
  output logic miso,
  output logic fault,
  output int   cmd0_seen,
  output int   cmd8_seen,
  output int   acmd41_seen,
  output int   cmd17_seen
);

  localparam int WANT_CMD0   = 0;
  localparam int WANT_CMD8   = 1;
  localparam int WANT_CMD55  = 2;
  localparam int WANT_ACMD41 = 3;
  localparam int READY       = 4;

  logic [47:0] rx_sh;
  int          rx_cnt;
  int          stage;
  bit          tx_q[$];  // Bits still to go out on miso

  // CRC7 by long division of the 40 frame bits times x^7 by x^7 + x^3 + 1
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [46:0] rem;
    rem = {bits, 7'd0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) rem[i -: 8] = rem[i -: 8] ^ 8'b1000_1001;
    end
    return rem[6:0];
  endfunction

  task automatic push_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) tx_q.push_back(b[i]);
  endtask

  task automatic flag(input string why);
    $display("Card model: %s", why);
    fault = 1'b1;
  endtask

  task automatic take_frame(input logic [47:0] f);
    sd_pkg::sd_cmd_t idx;
    logic [31:0]     arg;
    idx = sd_pkg::sd_cmd_t'(f[45:40]);
    arg = f[39:8];
    if (f[46] !== 1'b1 || f[0] !== 1'b1) begin
      flag("command frame has a bad transmission or end bit");
    end else if (f[7:1] !== crc7(f[47:8])) begin
      flag($sformatf("wrong CRC7 on command %0d", f[45:40]));
    end else begin
      push_byte(8'hFF);  // One byte of Ncr before the reply
      case (idx)
        sd_pkg::CMD_GO_IDLE: begin
          if (stage != WANT_CMD0) flag("CMD0 arrived out of the init order");
          cmd0_seen++;
          push_byte(8'h01);
          stage = WANT_CMD8;
        end
        sd_pkg::CMD_SEND_IF_COND: begin
          if (stage != WANT_CMD8) flag("CMD8 arrived out of the init order");
          if (arg !== 32'h0000_01AA) flag("CMD8 argument is not voltage 1 with pattern AA");
          cmd8_seen++;
          push_byte(8'h01);
          push_byte(arg[31:24]);
          push_byte(arg[23:16]);
          push_byte(arg[15:8]);
          push_byte(arg[7:0]);  // Echo of the check pattern
          stage = WANT_CMD55;
        end
        sd_pkg::CMD_APP: begin
          if (stage != WANT_CMD55) flag("CMD55 arrived out of the init order");
          push_byte(8'h01);
          stage = WANT_ACMD41;
        end
        sd_pkg::ACMD_SEND_OP_COND: begin
          if (stage != WANT_ACMD41) flag("ACMD41 arrived without a CMD55 before it");
          if (arg !== 32'h4000_0000) flag("ACMD41 argument does not set HCS");
          acmd41_seen++;
          if (acmd41_seen < 3) begin
            push_byte(8'h01);  // Still idle
            stage = WANT_CMD55;
          end else begin
            push_byte(8'h00);
            stage = READY;
          end
        end
        sd_pkg::CMD_READ_SINGLE: begin
          if (stage != READY) flag("CMD17 arrived before the card was ready");
          cmd17_seen++;
          if (arg < ADDR_LIMIT) begin
            push_byte(8'h00);
            push_byte(8'hFF);  // Nac gap
            push_byte(8'hFE);
            for (int i = 0; i < sd_pkg::BLOCK_BYTES; i++) begin
              push_byte((arg[7:0] + 8'(i)) ^ 8'h5A);
            end
            push_byte(8'hC3);  // Dummy CRC16
            push_byte(8'h3C);
          end else begin
            push_byte(8'h40);  // Parameter error
          end
        end
        default: flag($sformatf("unexpected command %0d", f[45:40]));
      endcase
    end
  endtask

  initial begin
    miso        = 1'b1;
    fault       = 1'b0;
    rx_cnt      = 0;
    stage       = WANT_CMD0;
    cmd0_seen   = 0;
    cmd8_seen   = 0;
    acmd41_seen = 0;
    cmd17_seen  = 0;
  end

  // Mode 0, mosi taken on the rising edge
  always @(posedge sck) begin
    if (cs) begin
      rx_cnt = 0;
    end else if (rx_cnt == 0) begin
      if (mosi === 1'b0) begin  // Start bit
        rx_sh  = 48'd0;
        rx_cnt = 1;
      end
    end else begin
      rx_sh = {rx_sh[46:0], mosi};
      rx_cnt++;
      if (rx_cnt == 48) begin
        take_frame(rx_sh);
        rx_cnt = 0;
      end
    end
  end

  always @(negedge sck) begin
    if (!cs && tx_q.size() > 0) miso <= tx_q.pop_front();
    else miso <= 1'b1;
  end

  always @(posedge cs) tx_q.delete();  // Deselect drops any unsent reply

endmodule

`default_nettype wire

//--- hw/sd_reader_top.sv
`timescale 1ns/10ps
`default_nettype none

module sd_reader_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        rd_req,
  input  logic [31:0] rd_addr,
  output logic        rd_ack,
  output logic        rd_error,
  output logic        init_done,
  output logic [7:0]  data_byte,
  output logic        data_strobe,
  input  logic        miso,
  output logic        cs,
  output logic        sck,
  output logic        mosi
);

  logic               fast;
  logic               sck_rise;
  logic               sck_fall;
  logic               cmd_req;
  logic               cmd_ack;
  sd_pkg::sd_cmd_t    cmd_index;
  logic [31:0]        cmd_arg;
  logic               resp_req;
  logic               resp_ack;
  sd_pkg::resp_kind_t resp_kind;
  logic [7:0]         resp_r1;
  logic [31:0]        resp_tail;
  logic               resp_timeout;

  sd_spi_clock u_clock (
    .clock    (clock),
    .reset    (reset),
    .fast     (fast),
    .sck      (sck),
    .sck_rise (sck_rise),
    .sck_fall (sck_fall)
  );

  sd_cmd_sender u_sender (
    .clock     (clock),
    .reset     (reset),
    .sck_fall  (sck_fall),
    .cmd_req   (cmd_req),
    .cmd_index (cmd_index),
    .cmd_arg   (cmd_arg),
    .cmd_ack   (cmd_ack),
    .mosi      (mosi)
  );

  sd_resp_receiver u_receiver (
    .clock        (clock),
    .reset        (reset),
    .sck_rise     (sck_rise),
    .resp_req     (resp_req),
    .resp_kind    (resp_kind),
    .miso         (miso),
    .resp_ack     (resp_ack),
    .resp_r1      (resp_r1),
    .resp_tail    (resp_tail),
    .resp_timeout (resp_timeout),
    .data_byte    (data_byte),
    .data_strobe  (data_strobe)
  );

  sd_controller u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr),
    .rd_ack       (rd_ack),
    .rd_error     (rd_error),
    .init_done    (init_done),
    .cs           (cs),
    .fast         (fast),
    .sck_rise     (sck_rise),
    .cmd_req      (cmd_req),
    .cmd_index    (cmd_index),
    .cmd_arg      (cmd_arg),
    .cmd_ack      (cmd_ack),
    .resp_req     (resp_req),
    .resp_kind    (resp_kind),
    .resp_ack     (resp_ack),
    .resp_r1      (resp_r1),
    .resp_tail    (resp_tail),
    .resp_timeout (resp_timeout)
  );

endmodule

`default_nettype wire

//--- hw/sd_controller.sv
`timescale 1ns/10ps
`default_nettype none

module sd_controller (
  input  logic               clock,
  input  logic               reset,
  input  logic               rd_req,
  input  logic [31:0]        rd_addr,
  output logic               rd_ack,
  output logic               rd_error,
  output logic               init_done,
  output logic               cs,
  output logic               fast,
  input  logic               sck_rise,
  output logic               cmd_req,
  output sd_pkg::sd_cmd_t    cmd_index,
  output logic [31:0]        cmd_arg,
  input  logic               cmd_ack,
  output logic               resp_req,
  output sd_pkg::resp_kind_t resp_kind,
  input  logic               resp_ack,
  input  logic [7:0]         resp_r1,
  input  logic [31:0]        resp_tail,
  input  logic               resp_timeout
);

  sd_pkg::ctrl_state_t state;
  sd_pkg::ctrl_state_t ret_state;
  logic [1:0]  phase;      // Step inside the exchange
  logic        have_resp;  // Back from an exchange, result latched
  logic [6:0]  pu_cnt;
  logic [7:0]  r1_q;
  logic [31:0] tail_q;
  logic        tmo_q;

  // Start a command exchange and come back to the current state
  task automatic issue(input sd_pkg::sd_cmd_t idx, input logic [31:0] arg,
                       input sd_pkg::resp_kind_t kind);
    cmd_index <= idx;
    cmd_arg   <= arg;
    resp_kind <= kind;
    cmd_req   <= 1'b1;
    cs        <= 1'b0;
    phase     <= 2'd0;
    ret_state <= state;
    state     <= sd_pkg::ST_WAIT_CMD;
  endtask

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= sd_pkg::ST_POWER_UP;
      ret_state <= sd_pkg::ST_POWER_UP;
      phase     <= 2'd0;
      have_resp <= 1'b0;
      pu_cnt    <= 7'd0;
      r1_q      <= 8'hFF;
      tail_q    <= 32'd0;
      tmo_q     <= 1'b0;
      rd_ack    <= 1'b0;
      rd_error  <= 1'b0;
      init_done <= 1'b0;
      cs        <= 1'b1;
      fast      <= 1'b0;
      cmd_req   <= 1'b0;
      cmd_index <= sd_pkg::CMD_GO_IDLE;
      cmd_arg   <= 32'd0;
      resp_req  <= 1'b0;
      resp_kind <= sd_pkg::RESP_R1;
    end else begin
      case (state)
        sd_pkg::ST_POWER_UP: begin
          cs <= 1'b1;  // Clocks with card deselected
          if (sck_rise) pu_cnt <= pu_cnt + 7'd1;
          if (pu_cnt == 7'(sd_pkg::POWER_UP_CLOCKS)) begin
            pu_cnt <= 7'd0;
            state  <= sd_pkg::ST_CMD0;
          end
        end
        sd_pkg::ST_CMD0: begin
          if (!have_resp) begin
            issue(sd_pkg::CMD_GO_IDLE, 32'd0, sd_pkg::RESP_R1);
          end else begin
            have_resp <= 1'b0;
            if (tmo_q) state <= sd_pkg::ST_POWER_UP;
            else if (r1_q == 8'h01) state <= sd_pkg::ST_CMD8;
          end
        end
        sd_pkg::ST_CMD8: begin
          if (!have_resp) begin
            issue(sd_pkg::CMD_SEND_IF_COND, sd_pkg::IF_COND_ARG, sd_pkg::RESP_R7);
          end else begin
            have_resp <= 1'b0;
            if (tmo_q) state <= sd_pkg::ST_POWER_UP;
            else if (tail_q[7:0] != sd_pkg::IF_COND_ARG[7:0]) state <= sd_pkg::ST_CMD8;
            else if (tail_q[11:8] != 4'h1) state <= sd_pkg::ST_POWER_UP;  // Voltage refused
            else state <= sd_pkg::ST_CMD55;
          end
        end
        sd_pkg::ST_CMD55: begin
          if (!have_resp) begin
            issue(sd_pkg::CMD_APP, 32'd0, sd_pkg::RESP_R1);
          end else begin
            have_resp <= 1'b0;
            if (tmo_q) state <= sd_pkg::ST_POWER_UP;
            else if (r1_q[7:1] == 7'd0) state <= sd_pkg::ST_ACMD41;
          end
        end
        sd_pkg::ST_ACMD41: begin
          if (!have_resp) begin
            issue(sd_pkg::ACMD_SEND_OP_COND, sd_pkg::OP_COND_ARG, sd_pkg::RESP_R1);
          end else begin
            have_resp <= 1'b0;
            if (tmo_q) begin
              state <= sd_pkg::ST_POWER_UP;
            end else if (r1_q == 8'h00) begin
              fast      <= 1'b1;  // Card left idle
              init_done <= 1'b1;
              state     <= sd_pkg::ST_IDLE;
            end else begin
              state <= sd_pkg::ST_CMD55;
            end
          end
        end
        sd_pkg::ST_IDLE: begin
          if (rd_req && !rd_ack && init_done) begin
            rd_error <= 1'b0;
            state    <= sd_pkg::ST_CMD17;
          end
        end
        sd_pkg::ST_CMD17: begin
          if (!have_resp) begin
            issue(sd_pkg::CMD_READ_SINGLE, rd_addr, sd_pkg::RESP_R1);
          end else begin
            have_resp <= 1'b0;
            if (tmo_q || r1_q != 8'h00) begin
              rd_error <= 1'b1;
              cs       <= 1'b1;
              state    <= sd_pkg::ST_DONE;
            end else begin
              // Card still selected, go straight to the block
              resp_kind <= sd_pkg::RESP_DATA;
              resp_req  <= 1'b1;
              phase     <= 2'd2;
              ret_state <= sd_pkg::ST_DATA;
              state     <= sd_pkg::ST_WAIT_CMD;
            end
          end
        end
        sd_pkg::ST_DATA: begin
          have_resp <= 1'b0;
          rd_error  <= tmo_q || (r1_q != sd_pkg::TOKEN_START);
          state     <= sd_pkg::ST_DONE;
        end
        sd_pkg::ST_DONE: begin
          rd_ack <= 1'b1;
          if (rd_ack && !rd_req) begin
            rd_ack <= 1'b0;
            state  <= sd_pkg::ST_IDLE;
          end
        end
        sd_pkg::ST_WAIT_CMD: begin
          case (phase)
            2'd0: if (cmd_ack) begin
              cmd_req <= 1'b0;
              phase   <= 2'd1;
            end
            2'd1: if (!cmd_ack) begin
              resp_req <= 1'b1;
              phase    <= 2'd2;
            end
            2'd2: if (resp_ack) begin
              r1_q     <= resp_r1;
              tail_q   <= resp_tail;
              tmo_q    <= resp_timeout;
              resp_req <= 1'b0;
              cs       <= (ret_state != sd_pkg::ST_CMD17);  // CMD17 keeps cs low for the block
              phase    <= 2'd3;
            end
            default: if (!resp_ack) begin
              have_resp <= 1'b1;
              state     <= ret_state;
            end
          endcase
        end
        default: state <= sd_pkg::ST_POWER_UP;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/sd_resp_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module sd_resp_receiver (
  input  logic               clock,
  input  logic               reset,
  input  logic               sck_rise,
  input  logic               resp_req,
  input  sd_pkg::resp_kind_t resp_kind,
  input  logic               miso,
  output logic               resp_ack,
  output logic [7:0]         resp_r1,
  output logic [31:0]        resp_tail,
  output logic               resp_timeout,
  output logic [7:0]         data_byte,
  output logic               data_strobe
);

  typedef enum logic [2:0] {
    R_IDLE,
    R_HUNT,
    R_R1,
    R_TAIL,
    R_TOKEN,
    R_DATA,
    R_CRC,
    R_DONE
  } recv_state_t;

  recv_state_t state;
  logic [7:0]  sh;
  logic [2:0]  bit_cnt;
  logic [9:0]  byte_cnt;
  logic [4:0]  tmo_cnt;
  logic [7:0]  next_byte;
  logic        byte_done;
  logic        tmo_hit;

  assign next_byte = {sh[6:0], miso};
  assign byte_done = sck_rise && (bit_cnt == 3'd7);
  assign tmo_hit   = (tmo_cnt == 5'(sd_pkg::RESP_TIMEOUT_BYTES - 1));

  always_ff @(posedge clock) begin
    if (sck_rise) sh <= next_byte;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state        <= R_IDLE;
      bit_cnt      <= 3'd0;
      byte_cnt     <= 10'd0;
      tmo_cnt      <= 5'd0;
      resp_ack     <= 1'b0;
      resp_r1      <= 8'hFF;
      resp_tail    <= 32'd0;
      resp_timeout <= 1'b0;
      data_byte    <= 8'd0;
      data_strobe  <= 1'b0;
    end else begin
      data_strobe <= 1'b0;
      if (sck_rise) bit_cnt <= bit_cnt + 3'd1;  // Free running, keeps byte alignment
      case (state)
        R_IDLE: begin
          if (resp_req) begin
            resp_timeout <= 1'b0;
            tmo_cnt      <= 5'd0;
            byte_cnt     <= 10'd0;
            state        <= (resp_kind == sd_pkg::RESP_DATA) ? R_TOKEN : R_HUNT;
          end
        end
        R_HUNT: begin
          if (sck_rise && !miso) begin
            bit_cnt <= 3'd1;  // Start bit is bit 0 of R1
            state   <= R_R1;
          end else if (byte_done) begin
            tmo_cnt <= tmo_cnt + 5'd1;
            if (tmo_hit) begin
              resp_timeout <= 1'b1;
              resp_r1      <= 8'hFF;
              resp_ack     <= 1'b1;
              state        <= R_DONE;
            end
          end
        end
        R_R1: begin
          if (byte_done) begin
            resp_r1 <= next_byte;
            if (resp_kind == sd_pkg::RESP_R7) begin
              state <= R_TAIL;
            end else begin
              resp_ack <= 1'b1;
              state    <= R_DONE;
            end
          end
        end
        R_TAIL: begin
          if (byte_done) begin
            resp_tail <= {resp_tail[23:0], next_byte};
            byte_cnt  <= byte_cnt + 10'd1;
            if (byte_cnt == 10'd3) begin
              resp_ack <= 1'b1;
              state    <= R_DONE;
            end
          end
        end
        R_TOKEN: begin
          if (byte_done) begin
            if (next_byte == sd_pkg::TOKEN_START) begin
              resp_r1 <= next_byte;
              state   <= R_DATA;
            end else if (next_byte != 8'hFF) begin
              resp_r1  <= next_byte;  // Data error token
              resp_ack <= 1'b1;
              state    <= R_DONE;
            end else begin
              tmo_cnt <= tmo_cnt + 5'd1;
              if (tmo_hit) begin
                resp_timeout <= 1'b1;
                resp_ack     <= 1'b1;
                state        <= R_DONE;
              end
            end
          end
        end
        R_DATA: begin
          if (byte_done) begin
            data_byte   <= next_byte;
            data_strobe <= 1'b1;
            byte_cnt    <= byte_cnt + 10'd1;
            if (byte_cnt == 10'(sd_pkg::BLOCK_BYTES - 1)) begin
              byte_cnt <= 10'd0;
              state    <= R_CRC;
            end
          end
        end
        R_CRC: begin
          if (byte_done) begin
            byte_cnt <= byte_cnt + 10'd1;  // CRC16 dropped
            if (byte_cnt == 10'd1) begin
              resp_ack <= 1'b1;
              state    <= R_DONE;
            end
          end
        end
        R_DONE: begin
          if (!resp_req) begin
            resp_ack <= 1'b0;
            state    <= R_IDLE;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/sd_cmd_sender.sv
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_sender (
  input  logic              clock,
  input  logic              reset,
  input  logic              sck_fall,
  input  logic              cmd_req,
  input  sd_pkg::sd_cmd_t   cmd_index,
  input  logic [31:0]       cmd_arg,
  output logic              cmd_ack,
  output logic              mosi
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SHIFT,
    S_ACK
  } send_state_t;

  send_state_t state;
  logic [47:0] shreg;    // Idle byte then start, index, argument
  logic [6:0]  crc;
  logic [5:0]  bit_cnt;
  logic        crc_fb;

  assign crc_fb = shreg[47] ^ crc[6];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= S_IDLE;
      shreg   <= '1;
      crc     <= 7'd0;
      bit_cnt <= 6'd0;
      cmd_ack <= 1'b0;
      mosi    <= 1'b1;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_req) begin
            shreg   <= {8'hFF, 2'b01, cmd_index, cmd_arg};
            crc     <= 7'd0;
            bit_cnt <= 6'd0;
            state   <= S_SHIFT;
          end
        end
        S_SHIFT: begin
          if (sck_fall) begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt < 6'd48) begin
              mosi  <= shreg[47];
              shreg <= {shreg[46:0], 1'b1};
              if (bit_cnt >= 6'd8) begin
                crc <= {crc[5:0], 1'b0} ^ (crc_fb ? 7'h09 : 7'h00);  // x^7 + x^3 + 1
              end
            end else if (bit_cnt < 6'd55) begin
              mosi <= crc[6];
              crc  <= {crc[5:0], 1'b0};
            end else if (bit_cnt == 6'd55) begin
              mosi <= 1'b1;  // End bit
            end else begin
              // End bit has now been on the line a full period
              mosi    <= 1'b1;
              cmd_ack <= 1'b1;
              state   <= S_ACK;
            end
          end
        end
        S_ACK: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/sd_spi_clock.sv
`timescale 1ns/10ps
`default_nettype none

module sd_spi_clock (
  input  logic clock,
  input  logic reset,
  input  logic fast,
  output logic sck,
  output logic sck_rise,
  output logic sck_fall
);

  logic [7:0] half_cnt;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      half_cnt <= 8'(sd_pkg::SLOW_HALF - 1);
      sck      <= 1'b0;  // Mode 0 idles low
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      if (half_cnt == 8'd0) begin
        // Rate is picked up only here
        half_cnt <= fast ? 8'(sd_pkg::FAST_HALF - 1) : 8'(sd_pkg::SLOW_HALF - 1);
        sck      <= ~sck;
        sck_rise <= ~sck;  // Pulse lines up with the new sck level
        sck_fall <= sck;
      end else begin
        half_cnt <= half_cnt - 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/sd_pkg.sv
`default_nettype none

package sd_pkg;

  // Command indexes as sent in the frame
  typedef enum logic [5:0] {
    CMD_GO_IDLE       = 6'd0,
    CMD_SEND_IF_COND  = 6'd8,
    CMD_READ_SINGLE   = 6'd17,
    ACMD_SEND_OP_COND = 6'd41,
    CMD_APP           = 6'd55
  } sd_cmd_t;

  typedef enum logic [1:0] {
    RESP_R1,    // Single R1 byte
    RESP_R7,    // R1 plus 4 payload bytes
    RESP_DATA   // Token, block, 2 CRC bytes
  } resp_kind_t;

  typedef enum logic [3:0] {
    ST_POWER_UP,
    ST_CMD0,
    ST_CMD8,
    ST_CMD55,
    ST_ACMD41,
    ST_IDLE,
    ST_CMD17,
    ST_DATA,
    ST_DONE,
    ST_WAIT_CMD
  } ctrl_state_t;

  localparam int BLOCK_BYTES        = 512;
  localparam int SLOW_HALF          = 8;   // 62 for 400 kHz from 50 MHz on hardware
  localparam int FAST_HALF          = 2;
  localparam int POWER_UP_CLOCKS    = 80;
  localparam int RESP_TIMEOUT_BYTES = 16;

  localparam logic [31:0] IF_COND_ARG = 32'h0000_01AA;  // Voltage 2.7-3.6 V, pattern AA
  localparam logic [31:0] OP_COND_ARG = 32'h4000_0000;  // HCS set
  localparam logic [7:0]  TOKEN_START = 8'hFE;

endpackage

`default_nettype wire
